// File: bench/fu_alu_cluster_props.sv
`timescale 1ns/10ps

module fu_alu_cluster_props (
    input logic                    clock,
    input logic                    rst_n,
    input logic                    issue_valid,
    input fu_types_pkg::inst_t     issue_inst,
    input fu_types_pkg::addr_t     issue_pc,
    input fu_types_pkg::data_t     issue_op1,
    input fu_types_pkg::data_t     issue_op2,
    input fu_types_pkg::alu_func_t issue_func,
    input fu_types_pkg::opa_sel_t  issue_opa_sel,
    input fu_types_pkg::opb_sel_t  issue_opb_sel,
    input logic                    issue_cond_branch,
    input logic                    issue_uncond_branch,
    input fu_types_pkg::prn_t      issue_prn,
    input fu_types_pkg::robn_t     issue_robn,
    input logic                    cdb_credit,
    input logic                    issue_credit,
    input logic                    cdb_valid,
    input fu_types_pkg::robn_t     cdb_robn,
    input fu_types_pkg::prn_t      cdb_prn,
    input fu_types_pkg::data_t     cdb_result,
    input logic                    cdb_branch,
    input logic                    cdb_taken
);
    import fu_types_pkg::*;
    import fu_cfg_pkg::*;

    data_t      exp_result [32];
    prn_t       exp_prn    [32];
    logic [1:0] exp_flags  [32];  // branch, taken
    logic       pending    [32];
    int         cdb_slots, up_credits;
    logic       failed = 1'b0;
    logic       seen_edge = 1'b0;
    logic       was_reset;
    data_t      want_result;
    prn_t       want_prn;
    logic [1:0] want_flags;
    logic       want_pending;

    // operand b as the RV32 formats place the immediate bits
    function automatic data_t operand_b(input inst_t i, input data_t op2, input opb_sel_t sel);
        data_t i_form;
        i_form = data_t'($signed(i) >>> 20);
        case (sel)
            OPB_IS_RS2:   return op2;
            OPB_IS_I_IMM: return i_form;
            OPB_IS_S_IMM: return {i_form[31:5], i[11:7]};
            OPB_IS_B_IMM: return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            OPB_IS_U_IMM: return i & 32'hffff_f000;
            default:      return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};  // j
        endcase
    endfunction

    function automatic data_t alu_ref(input alu_func_t f, input data_t a, input data_t b);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            default:  return data_t'($signed(a) >>> b[4:0]);  // sra
        endcase
    endfunction

    function automatic logic cond_holds(input logic [2:0] f3, input data_t x, input data_t y);
        logic lt_s, lt_u;
        lt_u = x < y;
        lt_s = (x ^ 32'h8000_0000) < (y ^ 32'h8000_0000);  // flip sign bits for signed order
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return lt_s;
            3'b101:  return !lt_s;
            3'b110:  return lt_u;
            default: return !lt_u;
        endcase
    endfunction

    assign want_result  = exp_result[cdb_robn];
    assign want_prn     = exp_prn[cdb_robn];
    assign want_flags   = exp_flags[cdb_robn];
    assign want_pending = pending[cdb_robn];

    // expected outcome kept per robn until it shows up on the result bus
    always @(posedge clock) begin : model
        data_t opa;
        opa = (issue_opa_sel == OPA_IS_PC) ? issue_pc : issue_op1;
        if (issue_opa_sel == OPA_IS_ZERO)
            opa = '0;
        seen_edge <= 1'b1;
        was_reset <= !rst_n;
        if (!rst_n) begin
            for (int k = 0; k < 32; k++)
                pending[k] <= 1'b0;
            cdb_slots   <= CDB_CREDITS;
            up_credits  <= ISSUE_DEPTH;
        end else begin
            if (cdb_valid)
                pending[cdb_robn] <= 1'b0;
            if (issue_valid) begin
                pending[issue_robn]    <= 1'b1;
                exp_prn[issue_robn]    <= issue_prn;
                exp_result[issue_robn] <= alu_ref(issue_func, opa,
                                                  operand_b(issue_inst, issue_op2, issue_opb_sel));
                exp_flags[issue_robn]  <= {issue_cond_branch || issue_uncond_branch,
                                           issue_uncond_branch || (issue_cond_branch &&
                                           cond_holds(issue_inst[14:12], issue_op1, issue_op2))};
            end
            cdb_slots   <= cdb_slots + int'(cdb_credit) - int'(cdb_valid);
            up_credits  <= up_credits + int'(issue_credit) - int'(issue_valid);
        end
    end

    a_reset_quiet: assert property (@(posedge clock)
        seen_edge && (!rst_n || was_reset) |-> !cdb_valid && !issue_credit) else begin
        $error("cdb_valid or issue_credit active during reset or in the cycle after it");
        failed = 1'b1;
    end

    a_known_robn: assert property (@(posedge clock) disable iff (!rst_n)
        cdb_valid |-> want_pending) else begin
        $error("robn %0d on the result bus was never issued or came twice", $sampled(cdb_robn));
        failed = 1'b1;
    end

    a_result: assert property (@(posedge clock) disable iff (!rst_n)
        cdb_valid |-> cdb_result == want_result) else begin
        $error("Mismatch at %0t: cdb_result for robn %0d got %h expected %h", $time,
               $sampled(cdb_robn), $sampled(cdb_result), $sampled(want_result));
        failed = 1'b1;
    end

    a_prn: assert property (@(posedge clock) disable iff (!rst_n)
        cdb_valid |-> cdb_prn == want_prn) else begin
        $error("Mismatch at %0t: cdb_prn for robn %0d got %0d expected %0d", $time,
               $sampled(cdb_robn), $sampled(cdb_prn), $sampled(want_prn));
        failed = 1'b1;
    end

    a_flags: assert property (@(posedge clock) disable iff (!rst_n)
        cdb_valid |-> {cdb_branch, cdb_taken} == want_flags) else begin
        $error("Mismatch at %0t: {cdb_branch,cdb_taken} got %b expected %b", $time,
               $sampled({cdb_branch, cdb_taken}), $sampled(want_flags));
        failed = 1'b1;
    end

    a_cdb_credit: assert property (@(posedge clock) disable iff (!rst_n)
        cdb_valid |-> cdb_slots > 0) else begin
        $error("a result went out on the result bus with no credit left");
        failed = 1'b1;
    end

    a_issue_credit: assert property (@(posedge clock) disable iff (!rst_n)
        issue_credit |-> up_credits - int'(issue_valid) < ISSUE_DEPTH) else begin
        $error("issue credit returned beyond the issue buffer depth");
        failed = 1'b1;
    end

endmodule

bind fu_alu_cluster fu_alu_cluster_props u_props (.*);

// File: bench/tb_fu_alu_cluster.sv
`timescale 1ns/10ps

module tb_fu_alu_cluster;
    import fu_types_pkg::*;
    import fu_cfg_pkg::*;

    localparam int N_OPS          = 600;
    localparam int TIMEOUT_CYCLES = 20000;  // about ten times a full run with stalls

    logic      clock, rst_n;
    logic      issue_valid, issue_cond_branch, issue_uncond_branch, cdb_credit;
    inst_t     issue_inst;
    addr_t     issue_pc;
    data_t     issue_op1, issue_op2;
    alu_func_t issue_func;
    opa_sel_t  issue_opa_sel;
    opb_sel_t  issue_opb_sel;
    prn_t      issue_prn;
    robn_t     issue_robn;
    logic      issue_credit, cdb_valid, cdb_branch, cdb_taken;
    robn_t     cdb_robn;
    prn_t      cdb_prn;
    data_t     cdb_result;

    int up_credits = ISSUE_DEPTH;  // upstream credit model
    int owed = 0;                  // result slots not yet handed back
    int issued = 0;
    int received = 0;
    int plain_cnt = 0;
    int br_cnt = 0;
    int hold_left = 0;
    int cycles = 0;
    logic end_ok = 1'b1;

    fu_alu_cluster DUT (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    always @(negedge clock) begin
        cycles++;
        if (DUT.u_props.failed)
            abort_run("a property check failed, see the error above");
        else if (cycles >= TIMEOUT_CYCLES)
            abort_run("timeout, results stopped arriving on the result bus");
    end

    task automatic drive_op();
        int kind;
        int k;
        kind                = $urandom_range(0, 9);
        issue_inst          = $urandom();
        issue_pc            = $urandom() & 32'hffff_fffc;
        issue_op1           = $urandom();
        issue_op2           = ($urandom_range(0, 3) == 0) ? issue_op1 : $urandom();  // ties
        issue_prn           = prn_t'($urandom());
        issue_robn          = robn_t'(issued);  // in flight count stays far below 32
        issue_cond_branch   = 1'b0;
        issue_uncond_branch = 1'b0;
        if (kind < 2) begin
            k = br_cnt % 6;  // walk the six branch funct3 codes
            issue_inst[14:12] = 3'(k < 2 ? k : k + 2);
            issue_func        = ALU_ADD;
            issue_opa_sel     = OPA_IS_PC;
            issue_opb_sel     = OPB_IS_B_IMM;
            issue_cond_branch = 1'b1;
            br_cnt++;
        end else if (kind == 2) begin
            issue_func          = ALU_ADD;
            issue_uncond_branch = 1'b1;
            issue_opa_sel       = $urandom_range(0, 1) ? OPA_IS_PC : OPA_IS_RS1;  // jal or jalr
            issue_opb_sel       = (issue_opa_sel == OPA_IS_PC) ? OPB_IS_J_IMM : OPB_IS_I_IMM;
        end else begin
            // sweep every function with every a/b select pair
            issue_func    = alu_func_t'(plain_cnt % 10);
            issue_opa_sel = opa_sel_t'((plain_cnt / 10) % 3);
            issue_opb_sel = opb_sel_t'((plain_cnt / 30) % 6);
            plain_cnt++;
        end
        issue_valid = 1'b1;
        issued++;
    endtask

    initial begin
        rst_n               = 1'b0;
        issue_valid         = 1'b0;
        issue_inst          = '0;
        issue_pc            = '0;
        issue_op1           = '0;
        issue_op2           = '0;
        issue_func          = ALU_ADD;
        issue_opa_sel       = OPA_IS_RS1;
        issue_opb_sel       = OPB_IS_RS2;
        issue_cond_branch   = 1'b0;
        issue_uncond_branch = 1'b0;
        issue_prn           = '0;
        issue_robn          = '0;
        cdb_credit          = 1'b0;
        void'($urandom(32'h80b6));
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        while (received < N_OPS) begin
            @(negedge clock);
            up_credits += int'(issue_credit);  // credit for this cycle's dispatch
            if (cdb_valid) begin
                received++;
                owed++;
            end
            issue_valid = 1'b0;
            if (issued < N_OPS && up_credits > 0 && $urandom_range(0, 3) != 0) begin
                drive_op();
                up_credits--;
            end
            cdb_credit = 1'b0;
            if (hold_left > 0)
                hold_left--;
            else if ($urandom_range(0, 99) == 0)
                hold_left = $urandom_range(20, 80);  // consumer keeps its slots for a while
            else if (owed > 0 && $urandom_range(0, 2) == 0) begin
                cdb_credit = 1'b1;
                owed--;
            end
        end

        @(negedge clock);
        issue_valid = 1'b0;
        cdb_credit  = 1'b0;
        @(negedge clock);  // model and last assertions have settled

        assert (up_credits == ISSUE_DEPTH) else begin
            $error("Mismatch at %0t: up_credits got %0d expected %0d", $time, up_credits,
                   ISSUE_DEPTH);
            end_ok = 1'b0;
        end
        for (int k = 0; k < 32; k++) begin
            assert (DUT.u_props.pending[k] == 1'b0) else begin
                $error("robn %0d was issued but never reached the result bus", k);
                end_ok = 1'b0;
            end
        end

        if (end_ok && !DUT.u_props.failed) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run("end of run checks failed");
        end
    end

endmodule

// File: files.f
verilog/fu_types_pkg.sv
verilog/fu_cfg_pkg.sv
verilog/issue_buffer.sv
verilog/alu_lane.sv
verilog/completion_arbiter.sv
verilog/fu_alu_cluster.sv
bench/fu_alu_cluster_props.sv
bench/tb_fu_alu_cluster.sv

// File: verilog/alu_lane.sv
`timescale 1ns/10ps

module alu_lane (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    lane_start,
    input  fu_types_pkg::inst_t     disp_inst,
    input  fu_types_pkg::addr_t     disp_pc,
    input  fu_types_pkg::data_t     disp_op1,
    input  fu_types_pkg::data_t     disp_op2,
    input  fu_types_pkg::alu_func_t disp_func,
    input  fu_types_pkg::opa_sel_t  disp_opa_sel,
    input  fu_types_pkg::opb_sel_t  disp_opb_sel,
    input  logic                    disp_cond_branch,
    input  logic                    disp_uncond_branch,
    input  fu_types_pkg::prn_t      disp_prn,
    input  fu_types_pkg::robn_t     disp_robn,
    input  logic                    take,
    output logic                    lane_free,
    output logic                    done,
    output fu_types_pkg::robn_t     res_robn,
    output fu_types_pkg::prn_t      res_prn,
    output fu_types_pkg::data_t     res_result,
    output logic                    res_branch,
    output logic                    res_taken
);
    import fu_types_pkg::*;

    data_t      opa, opb, alu_out;
    logic [2:0] funct3;
    logic       cmp_true;
    logic       full;

    assign funct3 = disp_inst[14:12];

    always_comb begin
        case (disp_opa_sel)
            OPA_IS_RS1:  opa = disp_op1;
            OPA_IS_PC:   opa = disp_pc;
            OPA_IS_ZERO: opa = '0;
            default:     opa = OPA_POISON;
        endcase
    end

    always_comb begin
        case (disp_opb_sel)
            OPB_IS_RS2:   opb = disp_op2;
            OPB_IS_I_IMM: opb = imm_i(disp_inst);
            OPB_IS_S_IMM: opb = imm_s(disp_inst);
            OPB_IS_B_IMM: opb = imm_b(disp_inst);
            OPB_IS_U_IMM: opb = imm_u(disp_inst);
            OPB_IS_J_IMM: opb = imm_j(disp_inst);
            default:      opb = OPB_POISON;
        endcase
    end

    // for a branch this is the target, pc plus the b immediate
    always_comb begin
        case (disp_func)
            ALU_ADD:  alu_out = opa + opb;
            ALU_SUB:  alu_out = opa - opb;
            ALU_SLT:  alu_out = data_t'($signed(opa) < $signed(opb));
            ALU_SLTU: alu_out = data_t'(opa < opb);
            ALU_AND:  alu_out = opa & opb;
            ALU_OR:   alu_out = opa | opb;
            ALU_XOR:  alu_out = opa ^ opb;
            ALU_SLL:  alu_out = opa << opb[4:0];
            ALU_SRL:  alu_out = opa >> opb[4:0];
            ALU_SRA:  alu_out = $signed(opa) >>> opb[4:0];
            default:  alu_out = ALU_POISON;
        endcase
    end

    // branch compare always looks at the register operands
    always_comb begin
        case (funct3)
            3'b000:  cmp_true = disp_op1 == disp_op2;                    // beq
            3'b001:  cmp_true = disp_op1 != disp_op2;                    // bne
            3'b100:  cmp_true = $signed(disp_op1) <  $signed(disp_op2);  // blt
            3'b101:  cmp_true = $signed(disp_op1) >= $signed(disp_op2);  // bge
            3'b110:  cmp_true = disp_op1 <  disp_op2;                    // bltu
            3'b111:  cmp_true = disp_op1 >= disp_op2;                    // bgeu
            default: cmp_true = 1'b0;
        endcase
    end

    assign done      = full;
    assign lane_free = !full || take;  // free again in the cycle it drains

    always_ff @(posedge clock) begin
        if (!rst_n)
            full <= 1'b0;
        else if (lane_start)
            full <= 1'b1;
        else if (take)
            full <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (lane_start) begin
            res_robn   <= disp_robn;
            res_prn    <= disp_prn;
            res_result <= alu_out;
            res_branch <= disp_cond_branch || disp_uncond_branch;
            res_taken  <= disp_uncond_branch || (disp_cond_branch && cmp_true);
        end
    end

endmodule

// File: verilog/completion_arbiter.sv
`timescale 1ns/10ps

module completion_arbiter (
    input  logic                                                        clock,
    input  logic                                                        rst_n,
    input  logic [fu_cfg_pkg::NUM_ALU_LANES-1:0]                        done,
    input  fu_types_pkg::robn_t [fu_cfg_pkg::NUM_ALU_LANES-1:0]         res_robn,
    input  fu_types_pkg::prn_t  [fu_cfg_pkg::NUM_ALU_LANES-1:0]         res_prn,
    input  fu_types_pkg::data_t [fu_cfg_pkg::NUM_ALU_LANES-1:0]         res_result,
    input  logic [fu_cfg_pkg::NUM_ALU_LANES-1:0]                        res_branch,
    input  logic [fu_cfg_pkg::NUM_ALU_LANES-1:0]                        res_taken,
    input  logic                                                        cdb_credit,
    output logic [fu_cfg_pkg::NUM_ALU_LANES-1:0]                        take,
    output logic                                                        cdb_valid,
    output fu_types_pkg::robn_t                                         cdb_robn,
    output fu_types_pkg::prn_t                                          cdb_prn,
    output fu_types_pkg::data_t                                         cdb_result,
    output logic                                                        cdb_branch,
    output logic                                                        cdb_taken
);
    import fu_types_pkg::*;
    import fu_cfg_pkg::*;

    cdb_cnt_t  cdb_cnt;   // result slots still granted
    lane_idx_t last_sel;  // lane served most recently
    lane_idx_t sel;
    logic      found;
    logic      have_credit;

    assign have_credit = (cdb_cnt != '0);

    // search starts one past the last lane served
    always_comb begin
        int idx;
        take  = '0;
        sel   = last_sel;
        found = 1'b0;
        for (int k = 1; k <= NUM_ALU_LANES; k++) begin
            idx = (int'(last_sel) + k) % NUM_ALU_LANES;
            if (!found && have_credit && done[idx]) begin
                found = 1'b1;
                sel   = lane_idx_t'(idx);
            end
        end
        take[sel] = found;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
            cdb_cnt   <= cdb_cnt_t'(CDB_CREDITS);
            last_sel  <= lane_idx_t'(NUM_ALU_LANES - 1);  // lane 0 first
        end else begin
            cdb_valid <= found;
            cdb_cnt   <= cdb_cnt + cdb_cnt_t'(cdb_credit) - cdb_cnt_t'(found);
            if (found)
                last_sel <= sel;
        end
    end

    always_ff @(posedge clock) begin
        if (found) begin
            cdb_robn   <= res_robn[sel];
            cdb_prn    <= res_prn[sel];
            cdb_result <= res_result[sel];
            cdb_branch <= res_branch[sel];
            cdb_taken  <= res_taken[sel];
        end
    end

endmodule

// File: verilog/fu_alu_cluster.sv
`timescale 1ns/10ps

module fu_alu_cluster (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    issue_valid,
    input  fu_types_pkg::inst_t     issue_inst,
    input  fu_types_pkg::addr_t     issue_pc,
    input  fu_types_pkg::data_t     issue_op1,
    input  fu_types_pkg::data_t     issue_op2,
    input  fu_types_pkg::alu_func_t issue_func,
    input  fu_types_pkg::opa_sel_t  issue_opa_sel,
    input  fu_types_pkg::opb_sel_t  issue_opb_sel,
    input  logic                    issue_cond_branch,
    input  logic                    issue_uncond_branch,
    input  fu_types_pkg::prn_t      issue_prn,
    input  fu_types_pkg::robn_t     issue_robn,
    input  logic                    cdb_credit,
    output logic                    issue_credit,
    output logic                    cdb_valid,
    output fu_types_pkg::robn_t     cdb_robn,
    output fu_types_pkg::prn_t      cdb_prn,
    output fu_types_pkg::data_t     cdb_result,
    output logic                    cdb_branch,
    output logic                    cdb_taken
);
    import fu_types_pkg::*;
    import fu_cfg_pkg::*;

    // shared dispatch bus, only the started lane samples it
    inst_t     disp_inst;
    addr_t     disp_pc;
    data_t     disp_op1, disp_op2;
    alu_func_t disp_func;
    opa_sel_t  disp_opa_sel;
    opb_sel_t  disp_opb_sel;
    logic      disp_cond_branch, disp_uncond_branch;
    prn_t      disp_prn;
    robn_t     disp_robn;

    logic [NUM_ALU_LANES-1:0] lane_free, lane_start, done, take;
    logic [NUM_ALU_LANES-1:0] res_branch, res_taken;
    robn_t [NUM_ALU_LANES-1:0] res_robn;
    prn_t  [NUM_ALU_LANES-1:0] res_prn;
    data_t [NUM_ALU_LANES-1:0] res_result;

    issue_buffer u_issue_buffer (
        .clock, .rst_n, .issue_valid, .issue_inst, .issue_pc, .issue_op1, .issue_op2,
        .issue_func, .issue_opa_sel, .issue_opb_sel, .issue_cond_branch,
        .issue_uncond_branch, .issue_prn, .issue_robn, .lane_free,
        .issue_credit, .lane_start, .disp_inst, .disp_pc, .disp_op1, .disp_op2,
        .disp_func, .disp_opa_sel, .disp_opb_sel, .disp_cond_branch,
        .disp_uncond_branch, .disp_prn, .disp_robn
    );

    for (genvar i = 0; i < NUM_ALU_LANES; i++) begin : g_lane
        alu_lane u_alu_lane (
            .clock, .rst_n,
            .lane_start (lane_start[i]),
            .disp_inst, .disp_pc, .disp_op1, .disp_op2, .disp_func,
            .disp_opa_sel, .disp_opb_sel, .disp_cond_branch, .disp_uncond_branch,
            .disp_prn, .disp_robn,
            .take       (take[i]),
            .lane_free  (lane_free[i]),
            .done       (done[i]),
            .res_robn   (res_robn[i]),
            .res_prn    (res_prn[i]),
            .res_result (res_result[i]),
            .res_branch (res_branch[i]),
            .res_taken  (res_taken[i])
        );
    end

    completion_arbiter u_completion_arbiter (
        .clock, .rst_n, .done, .res_robn, .res_prn, .res_result, .res_branch,
        .res_taken, .cdb_credit, .take, .cdb_valid, .cdb_robn, .cdb_prn,
        .cdb_result, .cdb_branch, .cdb_taken
    );

endmodule

// File: verilog/fu_cfg_pkg.sv
package fu_cfg_pkg;

    localparam int NUM_ALU_LANES = 3;
    localparam int ISSUE_DEPTH   = 4;  // also the upstream credit count
    localparam int CDB_CREDITS   = 2;  // result slots granted after reset

    typedef logic [1:0] lane_idx_t;

    // issue buffer pointers
    typedef logic [1:0] issue_ptr_t;

    // credit and occupancy counters, wide enough to hold the full count
    typedef logic [2:0] issue_cnt_t;
    typedef logic [2:0] cdb_cnt_t;

endpackage

// File: verilog/fu_types_pkg.sv
package fu_types_pkg;

    typedef logic [31:0] data_t;  // operand or result word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [5:0]  prn_t;   // physical register number
    typedef logic [4:0]  robn_t;  // reorder-buffer number

    // ALU function codes
    typedef logic [3:0] alu_func_t;
    localparam alu_func_t ALU_ADD  = 4'd0;
    localparam alu_func_t ALU_SUB  = 4'd1;
    localparam alu_func_t ALU_SLT  = 4'd2;
    localparam alu_func_t ALU_SLTU = 4'd3;
    localparam alu_func_t ALU_AND  = 4'd4;
    localparam alu_func_t ALU_OR   = 4'd5;
    localparam alu_func_t ALU_XOR  = 4'd6;
    localparam alu_func_t ALU_SLL  = 4'd7;
    localparam alu_func_t ALU_SRL  = 4'd8;
    localparam alu_func_t ALU_SRA  = 4'd9;

    // operand A sources
    typedef logic [1:0] opa_sel_t;
    localparam opa_sel_t OPA_IS_RS1  = 2'd0;
    localparam opa_sel_t OPA_IS_PC   = 2'd1;
    localparam opa_sel_t OPA_IS_ZERO = 2'd2;

    // operand B sources, the immediates come from the instruction word
    typedef logic [2:0] opb_sel_t;
    localparam opb_sel_t OPB_IS_RS2   = 3'd0;
    localparam opb_sel_t OPB_IS_I_IMM = 3'd1;
    localparam opb_sel_t OPB_IS_S_IMM = 3'd2;
    localparam opb_sel_t OPB_IS_B_IMM = 3'd3;
    localparam opb_sel_t OPB_IS_U_IMM = 3'd4;
    localparam opb_sel_t OPB_IS_J_IMM = 3'd5;

    // easy to spot in a waveform when a code is undefined
    localparam data_t OPA_POISON = 32'hdeadface;
    localparam data_t OPB_POISON = 32'hfacefeed;
    localparam data_t ALU_POISON = 32'hfacebeec;

    function automatic data_t imm_i(input inst_t inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic data_t imm_s(input inst_t inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    function automatic data_t imm_b(input inst_t inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic data_t imm_u(input inst_t inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic data_t imm_j(input inst_t inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

// File: verilog/issue_buffer.sv
`timescale 1ns/10ps

module issue_buffer (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 issue_valid,
    input  fu_types_pkg::inst_t                  issue_inst,
    input  fu_types_pkg::addr_t                  issue_pc,
    input  fu_types_pkg::data_t                  issue_op1,
    input  fu_types_pkg::data_t                  issue_op2,
    input  fu_types_pkg::alu_func_t              issue_func,
    input  fu_types_pkg::opa_sel_t               issue_opa_sel,
    input  fu_types_pkg::opb_sel_t               issue_opb_sel,
    input  logic                                 issue_cond_branch,
    input  logic                                 issue_uncond_branch,
    input  fu_types_pkg::prn_t                   issue_prn,
    input  fu_types_pkg::robn_t                  issue_robn,
    input  logic [fu_cfg_pkg::NUM_ALU_LANES-1:0] lane_free,
    output logic                                 issue_credit,
    output logic [fu_cfg_pkg::NUM_ALU_LANES-1:0] lane_start,
    output fu_types_pkg::inst_t                  disp_inst,
    output fu_types_pkg::addr_t                  disp_pc,
    output fu_types_pkg::data_t                  disp_op1,
    output fu_types_pkg::data_t                  disp_op2,
    output fu_types_pkg::alu_func_t              disp_func,
    output fu_types_pkg::opa_sel_t               disp_opa_sel,
    output fu_types_pkg::opb_sel_t               disp_opb_sel,
    output logic                                 disp_cond_branch,
    output logic                                 disp_uncond_branch,
    output fu_types_pkg::prn_t                   disp_prn,
    output fu_types_pkg::robn_t                  disp_robn
);
    import fu_types_pkg::*;
    import fu_cfg_pkg::*;

    inst_t     buf_inst     [ISSUE_DEPTH];
    addr_t     buf_pc       [ISSUE_DEPTH];
    data_t     buf_op1      [ISSUE_DEPTH];
    data_t     buf_op2      [ISSUE_DEPTH];
    alu_func_t buf_func     [ISSUE_DEPTH];
    opa_sel_t  buf_opa_sel  [ISSUE_DEPTH];
    opb_sel_t  buf_opb_sel  [ISSUE_DEPTH];
    logic      buf_cond     [ISSUE_DEPTH];
    logic      buf_uncond   [ISSUE_DEPTH];
    prn_t      buf_prn      [ISSUE_DEPTH];
    robn_t     buf_robn     [ISSUE_DEPTH];

    issue_ptr_t head, tail;
    issue_cnt_t count;
    logic       dispatch;
    logic [NUM_ALU_LANES-1:0] lowest_free;

    // oldest entry goes out when any lane can take it
    assign dispatch     = (count != '0) && (|lane_free);
    assign lowest_free  = lane_free & ~(lane_free - 1'b1);  // isolate lowest set bit
    assign lane_start   = dispatch ? lowest_free : '0;
    assign issue_credit = dispatch;

    assign disp_inst          = buf_inst[head];
    assign disp_pc            = buf_pc[head];
    assign disp_op1           = buf_op1[head];
    assign disp_op2           = buf_op2[head];
    assign disp_func          = buf_func[head];
    assign disp_opa_sel       = buf_opa_sel[head];
    assign disp_opb_sel       = buf_opb_sel[head];
    assign disp_cond_branch   = buf_cond[head];
    assign disp_uncond_branch = buf_uncond[head];
    assign disp_prn           = buf_prn[head];
    assign disp_robn          = buf_robn[head];

    // upstream credits keep this from being written while full
    always_ff @(posedge clock) begin
        if (issue_valid) begin
            buf_inst[tail]    <= issue_inst;
            buf_pc[tail]      <= issue_pc;
            buf_op1[tail]     <= issue_op1;
            buf_op2[tail]     <= issue_op2;
            buf_func[tail]    <= issue_func;
            buf_opa_sel[tail] <= issue_opa_sel;
            buf_opb_sel[tail] <= issue_opb_sel;
            buf_cond[tail]    <= issue_cond_branch;
            buf_uncond[tail]  <= issue_uncond_branch;
            buf_prn[tail]     <= issue_prn;
            buf_robn[tail]    <= issue_robn;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (issue_valid)
                tail <= (tail == issue_ptr_t'(ISSUE_DEPTH - 1)) ? '0 : tail + 1'b1;
            if (dispatch)
                head <= (head == issue_ptr_t'(ISSUE_DEPTH - 1)) ? '0 : head + 1'b1;
            count <= count + issue_cnt_t'(issue_valid) - issue_cnt_t'(dispatch);
        end
    end

endmodule
